//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= === FAIL ===
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/icache_way.sv
rtl/icache_ctrl.sv
rtl/fetch_top.sv
testbench/fetch_chk.sv
testbench/fetch_monitor.sv
testbench/fetch_tb.sv

//--- rtl/fetch_pc_gen.sv
`default_nettype none

`include "fetch_settings.svh"

module fetch_pc_gen (
	input  logic             clk,
	input  logic             rst,
	input  logic             hit,
	input  fetch_pkg::inst_t inst,
	input  logic             inst_ready,
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,
	output fetch_pkg::addr_t fetch_pc,
	output logic             inst_valid
);

	// ****************************************
	// predecode of the delivered word
	// ****************************************

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic is_jal;
	logic is_branch;
	fetch_pkg::addr_t imm_j;
	fetch_pkg::addr_t imm_b;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];

	assign is_jal = (opcode == 7'b1101111);
	// beq bne blt bge bltu bgeu, funct3 010 and 011 are reserved
	assign is_branch = (opcode == 7'b1100011) && (funct3 != 3'b010) && (funct3 != 3'b011);

	// jal offset, sign from bit 31
	assign imm_j = {{(`FETCH_XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	// branch offset
	assign imm_b = {{(`FETCH_XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

	// ****************************************
	// handshake and pending redirect
	// ****************************************

	// redirect seen while the cache was refilling
	logic pend_valid;
	fetch_pkg::addr_t pend_pc;
	logic transfer;

	// a redirect or a parked redirect kills the shown word
	assign inst_valid = hit && !redirect && !pend_valid;
	assign transfer = inst_valid && inst_ready;

	// static prediction, backward branch taken
	fetch_pkg::addr_t predict_pc;

	always_comb begin
		if (is_jal) begin
			predict_pc = fetch_pc + imm_j;
		end else if (is_branch && inst[31]) begin
			predict_pc = fetch_pc + imm_b;
		end else begin
			predict_pc = fetch_pc + `FETCH_XLEN'd4;
		end
	end

	// ****************************************
	// pc register
	// ****************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc <= `FETCH_RESET_PC;
			pend_valid <= 1'b0;
		end else if (redirect) begin
			if (hit) begin
				// lookup idle, jump now
				fetch_pc <= redirect_pc;
				pend_valid <= 1'b0;
			end else begin
				// refill in flight, fetch_pc must stay on the line being filled
				pend_valid <= 1'b1;
			end
		end else if (pend_valid && hit) begin
			// refill done and written, now follow the redirect
			fetch_pc <= pend_pc;
			pend_valid <= 1'b0;
		end else if (transfer) begin
			fetch_pc <= predict_pc;
		end
	end

	// target of the parked redirect
	always_ff @(posedge clk) begin
		if (redirect && !hit) begin
			pend_pc <= redirect_pc;
		end
	end

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

	// ****************************************
	// datapath types
	// ****************************************

	// byte address
	typedef logic [`FETCH_XLEN-1:0] addr_t;
	// one instruction word
	typedef logic [`FETCH_XLEN-1:0] inst_t;
	// set index, taken above the word offset
	typedef logic [`FETCH_SET_BITS-1:0] set_idx_t;
	// address bits above the index
	typedef logic [`FETCH_TAG_BITS-1:0] tag_t;
	// one-hot way vector
	typedef logic [`FETCH_NUM_WAYS-1:0] way_sel_t;

	// refill fsm
	typedef enum logic [1:0] {
		IDLE,
		AR,
		R
	} refill_state_t;

endpackage

`default_nettype wire

//--- rtl/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// ****************************************
// fetch unit configuration
// ****************************************

// address and instruction width
`define FETCH_XLEN 32

// cache geometry, one word per line
`define FETCH_NUM_WAYS 2
`define FETCH_NUM_SETS 8

// byte offset of a word inside a line
`define FETCH_OFS_BITS 2

// derived index and tag widths
`define FETCH_SET_BITS $clog2(`FETCH_NUM_SETS)
`define FETCH_TAG_BITS (`FETCH_XLEN - `FETCH_SET_BITS - `FETCH_OFS_BITS)

// first fetch address after reset
`define FETCH_RESET_PC 32'h8000_0000

`endif

//--- rtl/fetch_top.sv
`default_nettype none

`include "fetch_settings.svh"

module fetch_top (
	input  logic             clk,
	input  logic             rst,
	// decode side
	output logic             inst_valid,
	input  logic             inst_ready,
	output fetch_pkg::inst_t inst,
	output fetch_pkg::addr_t pc,
	// redirect from a later stage
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,
	// axi4-lite read channels
	output fetch_pkg::addr_t araddr,
	output logic             arvalid,
	input  logic             arready,
	input  fetch_pkg::inst_t rdata,
	input  logic [1:0]       rresp,
	input  logic             rvalid,
	output logic             rready
);

	// ****************************************
	// internal nets
	// ****************************************

	logic hit;
	fetch_pkg::way_sel_t way_hit;
	fetch_pkg::inst_t way_data [`FETCH_NUM_WAYS];
	fetch_pkg::way_sel_t refill_we;
	fetch_pkg::inst_t refill_data;

	// pc register and prediction
	fetch_pc_gen u_pc_gen (
		.clk         (clk),
		.rst         (rst),
		.hit         (hit),
		.inst        (inst),
		.inst_ready  (inst_ready),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.fetch_pc    (pc),
		.inst_valid  (inst_valid)
	);

	// ways, all looked up with the same pc
	for (genvar g = 0; g < `FETCH_NUM_WAYS; g++) begin : g_way
		icache_way u_way (
			.clk         (clk),
			.rst         (rst),
			.fetch_pc    (pc),
			.refill_we   (refill_we[g]),
			.refill_data (refill_data),
			.way_hit     (way_hit[g]),
			.way_data    (way_data[g])
		);
	end

	// hit mux, refill and axi master
	icache_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.fetch_pc    (pc),
		.way_hit     (way_hit),
		.way_data    (way_data),
		.hit         (hit),
		.inst        (inst),
		.refill_we   (refill_we),
		.refill_data (refill_data),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready)
	);

endmodule

`default_nettype wire

//--- rtl/icache_ctrl.sv
`default_nettype none

`include "fetch_settings.svh"

module icache_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  fetch_pkg::addr_t    fetch_pc,
	input  fetch_pkg::way_sel_t way_hit,
	input  fetch_pkg::inst_t    way_data [`FETCH_NUM_WAYS],
	output logic                hit,
	output fetch_pkg::inst_t    inst,
	output fetch_pkg::way_sel_t refill_we,
	output fetch_pkg::inst_t    refill_data,
	output fetch_pkg::addr_t    araddr,
	output logic                arvalid,
	input  logic                arready,
	input  fetch_pkg::inst_t    rdata,
	input  logic [1:0]          rresp,
	input  logic                rvalid,
	output logic                rready
);

	// victim pointer width of at least one bit
	localparam int VICT_W = (`FETCH_NUM_WAYS > 1) ? $clog2(`FETCH_NUM_WAYS) : 1;

	// ****************************************
	// hit select
	// ****************************************

	assign hit = |way_hit;

	// ways are one-hot on a hit, so an or-mux is enough
	always_comb begin
		inst = '0;
		for (int i = 0; i < `FETCH_NUM_WAYS; i++) begin
			if (way_hit[i]) begin
				inst = inst | way_data[i];
			end
		end
	end

	// ****************************************
	// refill fsm
	// ****************************************

	fetch_pkg::refill_state_t state_q;
	fetch_pkg::refill_state_t state_d;
	logic miss;
	logic r_done;

	assign miss = !hit && (state_q == fetch_pkg::IDLE);
	// rresp is not acted on and every beat is taken as is
	assign r_done = (state_q == fetch_pkg::R) && rvalid;

	always_comb begin
		state_d = state_q;
		case (state_q)
			fetch_pkg::IDLE: begin
				if (miss) begin
					state_d = fetch_pkg::AR;
				end
			end
			fetch_pkg::AR: begin
				if (arready) begin
					state_d = fetch_pkg::R;
				end
			end
			fetch_pkg::R: begin
				if (r_done) begin
					state_d = fetch_pkg::IDLE;
				end
			end
			default: state_d = fetch_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= fetch_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// fetch_pc is frozen while refilling, so the address stays stable
	assign araddr = {fetch_pc[`FETCH_XLEN-1:`FETCH_OFS_BITS], {`FETCH_OFS_BITS{1'b0}}};
	assign arvalid = (state_q == fetch_pkg::AR);
	assign rready = (state_q == fetch_pkg::R);

	// ****************************************
	// round-robin victim per set
	// ****************************************

	fetch_pkg::set_idx_t idx;
	logic [VICT_W-1:0] victim_q [`FETCH_NUM_SETS];
	fetch_pkg::way_sel_t victim_oh;

	assign idx = fetch_pc[`FETCH_SET_BITS+`FETCH_OFS_BITS-1:`FETCH_OFS_BITS];
	assign victim_oh = fetch_pkg::way_sel_t'(1) << victim_q[idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `FETCH_NUM_SETS; s++) begin
				victim_q[s] <= '0;
			end
		end else if (r_done) begin
			// step to the next way and wrap after the last one
			if (victim_q[idx] == VICT_W'(`FETCH_NUM_WAYS - 1)) begin
				victim_q[idx] <= '0;
			end else begin
				victim_q[idx] <= victim_q[idx] + VICT_W'(1);
			end
		end
	end

	// write strobe lands in the r beat, lookup hits one cycle later
	assign refill_we = r_done ? victim_oh : '0;
	assign refill_data = rdata;

endmodule

`default_nettype wire

//--- rtl/icache_way.sv
`default_nettype none

`include "fetch_settings.svh"

module icache_way (
	input  logic             clk,
	input  logic             rst,
	input  fetch_pkg::addr_t fetch_pc,
	input  logic             refill_we,
	input  fetch_pkg::inst_t refill_data,
	output logic             way_hit,
	output fetch_pkg::inst_t way_data
);

	// ****************************************
	// address split
	// ****************************************

	fetch_pkg::set_idx_t idx;
	fetch_pkg::tag_t tag;

	assign idx = fetch_pc[`FETCH_SET_BITS+`FETCH_OFS_BITS-1:`FETCH_OFS_BITS];
	assign tag = fetch_pc[`FETCH_XLEN-1:`FETCH_SET_BITS+`FETCH_OFS_BITS];

	// ****************************************
	// arrays
	// ****************************************

	logic valid_q [`FETCH_NUM_SETS];
	fetch_pkg::tag_t tag_q [`FETCH_NUM_SETS];
	fetch_pkg::inst_t data_q [`FETCH_NUM_SETS];

	// valid bits, cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `FETCH_NUM_SETS; s++) begin
				valid_q[s] <= 1'b0;
			end
		end else if (refill_we) begin
			valid_q[idx] <= 1'b1;
		end
	end

	// tag and word, written at the set of the stalled pc
	always_ff @(posedge clk) begin
		if (refill_we) begin
			tag_q[idx] <= tag;
			data_q[idx] <= refill_data;
		end
	end

	// combinational lookup
	assign way_hit = valid_q[idx] && (tag_q[idx] == tag);
	assign way_data = data_q[idx];

endmodule

`default_nettype wire

//--- testbench/fetch_chk.sv
`default_nettype none

module fetch_chk (
	input  logic             clk,
	input  logic             rst,
	input  logic             inst_valid,
	input  logic             inst_ready,
	input  fetch_pkg::inst_t inst,
	input  fetch_pkg::addr_t pc,
	input  fetch_pkg::addr_t araddr,
	input  logic             arvalid,
	input  logic             arready,
	input  logic [1:0]       rresp,
	input  logic             rvalid,
	input  logic             rready
);

	timeunit 1ns;
	timeprecision 1ps;

	// read address held until accepted
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("read address dropped or changed before arready");

	// read data accepted in the cycle after the address
	r_accept: assert property (@(posedge clk) disable iff (rst)
		arvalid && arready |=> rready)
		else $error("rready not raised after the read address was accepted");

	// offered word held under back-pressure
	inst_hold: assert property (@(posedge clk) disable iff (rst)
		inst_valid && !inst_ready |=> $stable(pc) && $stable(inst))
		else $error("pc or inst changed while the word was stalled");

	// only okay responses expected
	resp_okay: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> rresp == 2'b00)
		else $error("read response other than okay");

	// quiet outputs right after reset
	reset_quiet: assert property (@(posedge clk)
		$fell(rst) |-> !inst_valid && !arvalid && !rready)
		else $error("handshake outputs active after reset");

endmodule

bind fetch_top fetch_chk u_chk (.*);

`default_nettype wire

//--- testbench/fetch_monitor.sv
`default_nettype none

`include "fetch_settings.svh"

module fetch_monitor #(
	parameter int MEM_WORDS = 64
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             inst_valid,
	input  logic             inst_ready,
	input  fetch_pkg::inst_t inst,
	input  fetch_pkg::addr_t pc,
	input  logic             redirect,
	input  fetch_pkg::addr_t redirect_pc,
	input  fetch_pkg::addr_t araddr,
	input  logic             arvalid,
	input  logic             arready,
	input  logic [31:0]      mem [MEM_WORDS],
	input  logic             final_check,
	input  logic [31:0]      exp_reads,
	output int               value_errs,
	output int               count_errs
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IW = $clog2(MEM_WORDS);
	localparam int VW = (`FETCH_NUM_WAYS > 1) ? $clog2(`FETCH_NUM_WAYS) : 1;

	// ****************************************
	// reference cache holding the full word address per entry
	// ****************************************

	logic m_valid [`FETCH_NUM_SETS][`FETCH_NUM_WAYS];
	fetch_pkg::addr_t m_addr [`FETCH_NUM_SETS][`FETCH_NUM_WAYS];
	logic [VW-1:0] m_ptr [`FETCH_NUM_SETS];
	int model_reads;
	int axi_reads;
	fetch_pkg::addr_t exp_pc;

	function automatic logic [31:0] mem_word(input fetch_pkg::addr_t a);
		logic [31:0] off;
		off = a - `FETCH_RESET_PC;
		if (off < 32'(MEM_WORDS * 4)) begin
			return mem[off[IW+1:2]];
		end
		return 32'h0;
	endfunction

	// static rule with jal and backward branches taken
	function automatic fetch_pkg::addr_t next_pc(input fetch_pkg::addr_t p, input logic [31:0] w);
		logic [31:0] j_off;
		logic [31:0] b_off;
		logic cond;
		j_off = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		b_off = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		cond = (w[6:0] == 7'h63) && (w[14:12] != 3'b010) && (w[14:12] != 3'b011);
		if (w[6:0] == 7'h6f) begin
			return p + j_off;
		end else if (cond && w[31]) begin
			return p + b_off;
		end
		return p + 32'd4;
	endfunction

	// a lookup that misses in the model costs one read
	task automatic model_lookup(input fetch_pkg::addr_t a);
		fetch_pkg::set_idx_t s;
		logic found;
		s = a[`FETCH_SET_BITS+1:2];
		found = 1'b0;
		for (int w = 0; w < `FETCH_NUM_WAYS; w++) begin
			if (m_valid[s][w] && m_addr[s][w] == a) begin
				found = 1'b1;
			end
		end
		if (!found) begin
			m_valid[s][m_ptr[s]] = 1'b1;
			m_addr[s][m_ptr[s]] = a;
			// round-robin per set
			if (m_ptr[s] == VW'(`FETCH_NUM_WAYS - 1)) begin
				m_ptr[s] = '0;
			end else begin
				m_ptr[s] = m_ptr[s] + VW'(1);
			end
			model_reads++;
		end
	endtask

	task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("FAILED %s: got %h, expected %h", name, got, exp);
		value_errs++;
	endtask

	// ****************************************
	// per-cycle comparison
	// ****************************************

	always @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `FETCH_NUM_SETS; s++) begin
				for (int w = 0; w < `FETCH_NUM_WAYS; w++) begin
					m_valid[s][w] = 1'b0;
				end
				m_ptr[s] = '0;
			end
			exp_pc = `FETCH_RESET_PC;
			model_reads = 0;
			axi_reads = 0;
			value_errs = 0;
			count_errs = 0;
		end else begin
			model_lookup(pc);
			if (arvalid && arready) begin
				axi_reads++;
				if (araddr != pc) begin
					report_value("araddr", araddr, pc);
				end
			end
			if (redirect) begin
				// word shown now must be dropped
				if (inst_valid) begin
					report_value("inst_valid", 32'(inst_valid), 32'h0);
				end
				exp_pc = redirect_pc;
			end else if (inst_valid && inst_ready) begin
				if (pc - `FETCH_RESET_PC >= 32'(MEM_WORDS * 4)) begin
					$display("error: an address outside the memory image was delivered");
					value_errs++;
				end
				if (pc != exp_pc) begin
					report_value("pc", pc, exp_pc);
				end
				if (inst != mem_word(pc)) begin
					report_value("inst", inst, mem_word(pc));
				end
				// next expected pc from the delivered word
				exp_pc = next_pc(pc, mem_word(pc));
			end
			if (final_check) begin
				if (32'(axi_reads) != 32'(model_reads)) begin
					$display("FAILED axi_reads: got %h, expected %h", axi_reads, model_reads);
					count_errs++;
				end
				if (32'(axi_reads) != exp_reads) begin
					$display("FAILED axi_reads: got %h, expected %h", axi_reads, exp_reads);
					count_errs++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/fetch_stimulus.txt
// header: image words, command rows, expected axi reads, deliveries to run
0000001a 00000003 0000000e 00000022
// memory image from 8000_0000, four words per line
00108093 00208093 00c0006f 00308093
00408093 00508093 00608093 fe009ce3
00009463 00908093 0380006f 00b08093
0000006f 00d08093 00e08093 00f08093
01008093 01108093 01208093 01308093
01408093 01508093 01608093 01708093
01808093 f9dff06f
// commands: delivery count, stall cycles, redirect target (0 means none)
00000004 00000005 00000000
0000000c 00000002 80000020
0000001b 00000003 80000030

//--- testbench/fetch_tb.sv
`default_nettype none

`include "fetch_settings.svh"

module fetch_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_WORDS = 64;
	localparam int STIM_WORDS = 128;
	localparam int IW = $clog2(MEM_WORDS);

	logic clk = 1'b0;
	logic rst;
	logic inst_valid;
	logic inst_ready;
	fetch_pkg::inst_t inst;
	fetch_pkg::addr_t pc;
	logic redirect;
	fetch_pkg::addr_t redirect_pc;
	fetch_pkg::addr_t araddr;
	logic arvalid;
	logic arready;
	fetch_pkg::inst_t rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [31:0] stim [STIM_WORDS];
	logic [31:0] mem [MEM_WORDS];
	int seed = 32'ha1e2_3126;
	int delivered;
	int n_words;
	int n_cmds;
	bit loaded = 1'b0;
	logic final_check;
	int value_errs;
	int count_errs;

	fetch_top DUT (.*);

	fetch_monitor #(.MEM_WORDS(MEM_WORDS)) u_monitor (
		.clk, .rst, .inst_valid, .inst_ready, .inst, .pc, .redirect, .redirect_pc,
		.araddr, .arvalid, .arready, .mem, .final_check,
		.exp_reads(stim[2]), .value_errs, .count_errs
	);

	// 40 ns period
	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (rst) begin
			delivered <= 0;
		end else if (inst_valid && inst_ready) begin
			delivered <= delivered + 1;
		end
	end

	// ****************************************
	// stimulus file and memory image
	// ****************************************

	task automatic load_stimulus();
		logic [31:0] a;
		for (int i = 0; i < MEM_WORDS; i++) begin
			// background words are plain alu ops tied to the address
			a = `FETCH_RESET_PC + 32'(i * 4);
			mem[i] = ((a ^ {a[15:0], a[31:16]}) & 32'hffff_ff80) | 32'h13;
		end
		for (int i = 0; i < STIM_WORDS; i++) begin
			stim[i] = '0;
		end
		$readmemh("testbench/fetch_stimulus.txt", stim);
		n_words = int'(stim[0]);
		n_cmds = int'(stim[1]);
		for (int i = 0; i < n_words; i++) begin
			mem[i] = stim[4 + i];
		end
	endtask

	// one axi4-lite read with random ar and r delays
	task automatic serve_read();
		logic [31:0] off;
		@(negedge clk);
		if (!rst && arvalid) begin
			repeat ($random(seed) & 3) @(negedge clk);
			off = araddr - `FETCH_RESET_PC;
			arready = 1'b1;
			@(negedge clk);
			arready = 1'b0;
			repeat ($random(seed) & 3) @(negedge clk);
			rdata = (off < 32'(MEM_WORDS * 4)) ? mem[off[IW+1:2]] : '0;
			rresp = 2'b00;
			rvalid = 1'b1;
			// beat taken at the first rising edge with rready high
			while (!rready) begin
				@(negedge clk);
			end
			@(negedge clk);
			rvalid = 1'b0;
		end
	endtask

	initial begin
		wait (loaded);
		forever serve_read();
	end

	// ****************************************
	// ready, stall and redirect sequencing
	// ****************************************

	initial begin
		int cmd;
		int stall_left;
		int base;
		rst = 1'b1;
		inst_ready = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		arready = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		rvalid = 1'b0;
		final_check = 1'b0;
		cmd = 0;
		stall_left = 0;
		load_stimulus();
		base = 4 + n_words;
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		while (delivered < int'(stim[3])) begin
			redirect = 1'b0;
			if (stall_left > 0) begin
				inst_ready = 1'b0;
				stall_left--;
			end else if (cmd < n_cmds && delivered >= int'(stim[base + 3 * cmd])) begin
				stall_left = int'(stim[base + 3 * cmd + 1]);
				if (stim[base + 3 * cmd + 2] != '0) begin
					redirect = 1'b1;
					redirect_pc = stim[base + 3 * cmd + 2];
				end
				inst_ready = 1'b1;
				cmd++;
			end else begin
				inst_ready = (($random(seed) & 3) != 0);
			end
			@(negedge clk);
		end
		inst_ready = 1'b0;
		redirect = 1'b0;
		final_check = 1'b1;
		@(negedge clk);
		final_check = 1'b0;
		@(negedge clk);
		$display("errors: %0d value, %0d read count, %0d total",
			value_errs, count_errs, value_errs + count_errs);
		if (value_errs + count_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// watchdog allows 20 cycles per command and per image word
	initial begin
		int limit;
		wait (loaded);
		limit = (n_cmds + n_words) * 20;
		repeat (limit) @(posedge clk);
		$display("timeout: the fetch sequence did not finish within %0d cycles", limit);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
